// ==== verilog/dma_params.svh ====
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

`define DMA_WORD_W       32    // Scratch memory word.
`define DMA_HALF_W       16    // One APB beat.
`define DMA_MEM_AW       6     // 64 words.

`define DESC_LEN_W       4     // Zero means 16 words.
`define DESC_ID_W        4
`define DESC_FIFO_DEPTH  4

`define APB_ADDR_W       4
`define SWITCH_W         8

`define LEDS_REG_ADDR    4'h0
`define SWITCH_REG_ADDR  4'h4

`endif

// ==== verilog/dma_pkg.sv ====
`include "dma_params.svh"

package dma_pkg;

  // Whole word for the memory side, two halves for the APB side.
  typedef union packed {
    logic [`DMA_WORD_W-1:0]            word;
    logic [1:0][`DMA_HALF_W-1:0]       half;  // Index 0 is the low half.
  } mem_word_u;

endpackage

// ==== verilog/dma_if.sv ====
`include "dma_params.svh"

interface desc_if;
  logic                    valid;
  logic                    ready;
  logic                    to_periph;  // 1 means memory to peripheral.
  logic                    sel;        // 1 selects the switches.
  logic [`DMA_MEM_AW-1:0]  addr;
  logic [`DESC_LEN_W-1:0]  len;
  logic [`DESC_ID_W-1:0]   id;

  modport source (output valid, to_periph, sel, addr, len, id, input ready);
  modport sink (input valid, to_periph, sel, addr, len, id, output ready);
endinterface

interface apb_if;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`APB_ADDR_W-1:0]  paddr;
  logic [`DMA_HALF_W-1:0]  pwdata;
  logic [`DMA_HALF_W-1:0]  prdata;
  logic                    pready;

  modport master (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready
  );
  modport slave (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready
  );
endinterface

// ==== verilog/desc_queue.sv ====
`include "dma_params.svh"

module desc_queue (
  input  logic                   aclk,
  input  logic                   i_rst,
  input  logic                   i_desc_valid,
  input  logic                   i_desc_to_periph,
  input  logic                   i_desc_sel,
  input  logic [`DMA_MEM_AW-1:0] i_desc_addr,
  input  logic [`DESC_LEN_W-1:0] i_desc_len,
  input  logic [`DESC_ID_W-1:0]  i_desc_id,
  output logic                   o_desc_ready,
  desc_if.source                 o_desc
);
  localparam int PTR_W   = $clog2(`DESC_FIFO_DEPTH);
  localparam int CNT_W   = $clog2(`DESC_FIFO_DEPTH + 1);
  localparam int ENTRY_W = 2 + `DMA_MEM_AW + `DESC_LEN_W + `DESC_ID_W;

  logic [ENTRY_W-1:0] fifo_mem [`DESC_FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;

  assign o_desc_ready = (count != CNT_W'(`DESC_FIFO_DEPTH));  // Low only when full.
  assign o_desc.valid = (count != '0);
  assign push = i_desc_valid && o_desc_ready;
  assign pop  = o_desc.valid && o_desc.ready;

  assign {o_desc.to_periph, o_desc.sel, o_desc.addr, o_desc.len, o_desc.id} = fifo_mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= {i_desc_to_periph, i_desc_sel, i_desc_addr, i_desc_len, i_desc_id};
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(`DESC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(`DESC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push and pop together.
      endcase
    end
  end

endmodule

// ==== verilog/dma_engine.sv ====
`include "dma_params.svh"

module dma_engine (
  input  logic                   aclk,
  input  logic                   i_rst,
  desc_if.sink                   i_desc,
  apb_if.master                  o_apb,
  input  logic                   i_mem_we,
  input  logic [`DMA_MEM_AW-1:0] i_mem_addr,
  input  logic [`DMA_WORD_W-1:0] i_mem_wdata,
  output logic                   o_resp_valid,
  input  logic                   i_resp_ready,
  output logic [`DESC_ID_W-1:0]  o_resp_id
);
  import dma_pkg::*;

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_SETUP   = 2'd1;
  localparam logic [1:0] ST_ACCESS  = 2'd2;
  localparam logic [1:0] ST_RESPOND = 2'd3;
  localparam logic [`DESC_LEN_W:0] ONE_WORD = {{`DESC_LEN_W{1'b0}}, 1'b1};

  logic [1:0]              state;
  logic                    half_idx;
  logic [`DESC_LEN_W:0]    words_left;  // One bit wider so that 16 fits.
  logic                    to_periph_r;
  logic                    sel_r;
  logic [`DMA_MEM_AW-1:0]  addr_r;
  logic [`DESC_ID_W-1:0]   id_r;
  mem_word_u               mem [2**`DMA_MEM_AW];
  mem_word_u               cur_word;
  mem_word_u               rd_word;
  mem_word_u               wb_word;
  logic                    accept;
  logic                    beat_done;
  logic                    word_done;

  assign i_desc.ready = (state == ST_IDLE);
  assign accept    = i_desc.valid && i_desc.ready;
  assign beat_done = (state == ST_ACCESS) && o_apb.pready;
  assign word_done = beat_done && half_idx;

  assign cur_word = mem[addr_r];

  assign o_apb.psel    = (state == ST_SETUP) || (state == ST_ACCESS);
  assign o_apb.penable = (state == ST_ACCESS);
  assign o_apb.pwrite  = to_periph_r;
  assign o_apb.paddr   = sel_r ? `SWITCH_REG_ADDR : `LEDS_REG_ADDR;
  assign o_apb.pwdata  = cur_word.half[half_idx];  // Low half goes first.

  assign o_resp_valid = (state == ST_RESPOND);
  assign o_resp_id    = id_r;

  // High half arrives on the bus while the low half waits in rd_word.
  always_comb begin
    wb_word.half[0] = rd_word.half[0];
    wb_word.half[1] = o_apb.prdata;
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state      <= ST_IDLE;
      half_idx   <= 1'b0;
      words_left <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state      <= ST_SETUP;
            half_idx   <= 1'b0;
            words_left <= {(i_desc.len == '0), i_desc.len};
          end
        end
        ST_SETUP: state <= ST_ACCESS;
        ST_ACCESS: begin
          if (o_apb.pready) begin
            half_idx <= ~half_idx;
            if (!half_idx) begin
              state <= ST_SETUP;
            end else if (words_left == ONE_WORD) begin
              state <= ST_RESPOND;
            end else begin
              words_left <= words_left - 1'b1;
              state      <= ST_SETUP;
            end
          end
        end
        ST_RESPOND: if (i_resp_ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      to_periph_r <= i_desc.to_periph;
      sel_r       <= i_desc.sel;
      addr_r      <= i_desc.addr;
      id_r        <= i_desc.id;
    end else if (word_done) begin
      addr_r <= addr_r + 1'b1;  // Ascending word order.
    end
    if (beat_done && !to_periph_r) rd_word.half[half_idx] <= o_apb.prdata;
  end

  always_ff @(posedge aclk) begin
    if (i_mem_we) begin
      mem[i_mem_addr] <= i_mem_wdata;  // Host load port.
    end else if (word_done && !to_periph_r) begin
      mem[addr_r] <= wb_word;
    end
  end

endmodule

// ==== verilog/apb_periph.sv ====
`include "dma_params.svh"

module apb_periph (
  input  logic                   aclk,
  input  logic                   i_rst,
  apb_if.slave                   i_apb,
  input  logic [`SWITCH_W-1:0]   i_switch,
  output logic [`DMA_HALF_W-1:0] o_leds
);
  logic                    access;
  logic                    led_hit;
  logic                    sw_hit;
  logic                    wait_q;
  logic [`DMA_HALF_W-1:0]  leds_reg;

  assign access  = i_apb.psel && i_apb.penable;
  assign led_hit = (i_apb.paddr == `LEDS_REG_ADDR);
  assign sw_hit  = (i_apb.paddr == `SWITCH_REG_ADDR);

  // Switch register answers in the second access cycle.
  assign i_apb.pready = access && (!sw_hit || wait_q);

  always_comb begin
    if (sw_hit) begin
      i_apb.prdata = {{(`DMA_HALF_W - `SWITCH_W){1'b0}}, i_switch};
    end else if (led_hit) begin
      i_apb.prdata = leds_reg;
    end else begin
      i_apb.prdata = '0;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      wait_q   <= 1'b0;
      leds_reg <= '0;
    end else begin
      wait_q <= access && sw_hit && !wait_q;
      if (access && i_apb.pwrite && led_hit) begin
        leds_reg <= i_apb.pwdata;  // Writes to the switch register fall through.
      end
    end
  end

  assign o_leds = leds_reg;

endmodule

// ==== verilog/dma_apb_top.sv ====
`include "dma_params.svh"

module dma_apb_top (
  input  logic                   aclk,
  input  logic                   i_rst,
  input  logic                   i_desc_valid,
  output logic                   o_desc_ready,
  input  logic                   i_desc_to_periph,
  input  logic                   i_desc_sel,
  input  logic [`DMA_MEM_AW-1:0] i_desc_addr,
  input  logic [`DESC_LEN_W-1:0] i_desc_len,
  input  logic [`DESC_ID_W-1:0]  i_desc_id,
  output logic                   o_resp_valid,
  input  logic                   i_resp_ready,
  output logic [`DESC_ID_W-1:0]  o_resp_id,
  input  logic                   i_mem_we,
  input  logic [`DMA_MEM_AW-1:0] i_mem_addr,
  input  logic [`DMA_WORD_W-1:0] i_mem_wdata,
  input  logic [`SWITCH_W-1:0]   i_switch,
  output logic [`DMA_HALF_W-1:0] o_leds
);
  desc_if desc_bus ();
  apb_if  apb_bus ();

  desc_queue desc_queue (
    .aclk             (aclk),
    .i_rst            (i_rst),
    .i_desc_valid     (i_desc_valid),
    .i_desc_to_periph (i_desc_to_periph),
    .i_desc_sel       (i_desc_sel),
    .i_desc_addr      (i_desc_addr),
    .i_desc_len       (i_desc_len),
    .i_desc_id        (i_desc_id),
    .o_desc_ready     (o_desc_ready),
    .o_desc           (desc_bus.source)
  );

  dma_engine dma_engine (
    .aclk             (aclk),
    .i_rst            (i_rst),
    .i_desc           (desc_bus.sink),
    .o_apb            (apb_bus.master),
    .i_mem_we         (i_mem_we),
    .i_mem_addr       (i_mem_addr),
    .i_mem_wdata      (i_mem_wdata),
    .o_resp_valid     (o_resp_valid),
    .i_resp_ready     (i_resp_ready),
    .o_resp_id        (o_resp_id)
  );

  apb_periph apb_periph (
    .aclk             (aclk),
    .i_rst            (i_rst),
    .i_apb            (apb_bus.slave),
    .i_switch         (i_switch),
    .o_leds           (o_leds)
  );

endmodule

// ==== verification/dma_chk.sv ====
`include "dma_params.svh"

module dma_chk (
  input logic                  aclk,
  input logic                  i_rst,
  input logic                  i_psel,
  input logic                  i_penable,
  input logic                  i_pready,
  input logic                  i_pwrite,
  input logic [`APB_ADDR_W-1:0] i_paddr,
  input logic                  i_resp_valid,
  input logic                  i_resp_ready,
  input logic [`DESC_ID_W-1:0] i_resp_id
);
  timeunit 1ns;
  timeprecision 1ps;

  a_setup_first: assert property (@(posedge aclk) disable iff (i_rst)
    (i_penable && !$past(i_penable)) |-> $past(i_psel))
    else $error("APB access cycle without a setup cycle before it");

  a_psel_hold: assert property (@(posedge aclk) disable iff (i_rst)
    (i_psel && !i_pready) |=> (i_psel && $stable(i_paddr) && $stable(i_pwrite)))
    else $error("APB transfer changed before pready");

  a_resp_hold: assert property (@(posedge aclk) disable iff (i_rst)
    (i_resp_valid && !i_resp_ready) |=> (i_resp_valid && $stable(i_resp_id)))
    else $error("Response dropped or changed before it was taken");

endmodule

bind dma_engine dma_chk apb_props (
  .aclk         (aclk),
  .i_rst        (i_rst),
  .i_psel       (o_apb.psel),
  .i_penable    (o_apb.penable),
  .i_pready     (o_apb.pready),
  .i_pwrite     (o_apb.pwrite),
  .i_paddr      (o_apb.paddr),
  .i_resp_valid (o_resp_valid),
  .i_resp_ready (i_resp_ready),
  .i_resp_id    (o_resp_id)
);

// ==== verification/dma_checker.sv ====
`include "dma_params.svh"

module dma_checker (
  input logic                   aclk,
  input logic                   i_rst,
  input logic                   i_desc_ready,
  input logic                   i_resp_valid,
  input logic                   i_resp_ready,
  input logic [`DESC_ID_W-1:0]  i_resp_id,
  input logic [`DMA_HALF_W-1:0] i_leds
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [`DMA_HALF_W-1:0] led_exp_q [$];
  logic [`DESC_ID_W-1:0]  id_exp_q [$];
  logic [`DMA_HALF_W-1:0] led_seen = '0;
  logic [`DMA_HALF_W-1:0] led_last_exp = '0;  // Value o_leds must hold at the end.
  logic [`DMA_HALF_W-1:0] exp_led;
  logic [`DESC_ID_W-1:0]  exp_id;
  logic                   rst_q = 1'b1;
  int                     resp_count = 0;
  int                     full_cycles = 0;
  int                     led_errors = 0;
  int                     resp_errors = 0;
  int                     misc_errors = 0;

  task automatic expect_led(input logic [`DMA_HALF_W-1:0] value);
    led_exp_q.push_back(value);
    led_last_exp = value;
  endtask

  task automatic expect_resp(input logic [`DESC_ID_W-1:0] id);
    id_exp_q.push_back(id);
  endtask

  always @(posedge aclk) begin
    rst_q <= i_rst;
    if (!i_rst) begin
      if (rst_q && (i_leds !== '0 || i_resp_valid !== 1'b0 || i_desc_ready !== 1'b1)) begin
        $display("error %0t: after reset leds %h resp_valid %b desc_ready %b",
                 $time, i_leds, i_resp_valid, i_desc_ready);
        misc_errors++;
      end
      if (!i_desc_ready) full_cycles <= full_cycles + 1;
      if (i_leds !== led_seen) begin
        led_seen <= i_leds;
        if (led_exp_q.size() == 0) begin
          $display("error %0t: o_leds changed to %h, no change expected", $time, i_leds);
          led_errors++;
        end else begin
          exp_led = led_exp_q.pop_front();
          if (i_leds !== exp_led) begin
            $display("error %0t: o_leds is %h, expected %h", $time, i_leds, exp_led);
            led_errors++;
          end
        end
      end
      if (i_resp_valid && i_resp_ready) begin
        resp_count <= resp_count + 1;
        if (id_exp_q.size() == 0) begin
          $display("error %0t: response id %h with no descriptor pending", $time, i_resp_id);
          resp_errors++;
        end else begin
          exp_id = id_exp_q.pop_front();
          if (i_resp_id !== exp_id) begin
            $display("error %0t: response id is %h, expected %h", $time, i_resp_id, exp_id);
            resp_errors++;
          end
        end
      end
    end
  end

  task automatic report();
    if (led_exp_q.size() != 0) begin
      $display("%0d expected LED values never appeared", led_exp_q.size());
      misc_errors++;
    end
    if (id_exp_q.size() != 0) begin
      $display("%0d descriptors never returned a response", id_exp_q.size());
      misc_errors++;
    end
    if (full_cycles == 0) begin
      $display("o_desc_ready never dropped while responses were held back");
      misc_errors++;
    end
    if (i_leds !== led_last_exp) begin
      $display("error %0t: o_leds ends at %h, expected %h", $time, i_leds, led_last_exp);
      led_errors++;
    end
    $display("Errors: leds %0d, responses %0d, other %0d (%0d responses seen)",
             led_errors, resp_errors, misc_errors, resp_count);
  endtask

  function automatic int error_total();
    return led_errors + resp_errors + misc_errors;
  endfunction

endmodule

// ==== verification/dma_tb.sv ====
`include "dma_params.svh"

module dma_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_AW      = `DMA_MEM_AW;
  localparam int MEM_WORDS   = 2**`DMA_MEM_AW;
  localparam int WORD_W      = `DMA_WORD_W;
  localparam int HALF_W      = `DMA_HALF_W;
  localparam int LEN_W       = `DESC_LEN_W;
  localparam int SW_W        = `SWITCH_W;
  localparam int RST_CYC     = 10;
  localparam int NUM_DESC    = 10;
  localparam int WORST_CYC   = 16 * 2 * 3 + 4;  // Sixteen words of switch reads.
  localparam int STALL_CYC   = 40;
  localparam int TIMEOUT_CYC = 2 * (NUM_DESC * WORST_CYC + MEM_WORDS + RST_CYC + STALL_CYC);

  logic                  aclk = 1'b0;
  logic                  rst;
  logic                  desc_valid;
  logic                  desc_ready;
  logic                  desc_to_periph;
  logic                  desc_sel;
  logic [MEM_AW-1:0]     desc_addr;
  logic [LEN_W-1:0]      desc_len;
  logic [`DESC_ID_W-1:0] desc_id;
  logic                  resp_valid;
  logic                  resp_ready;
  logic [`DESC_ID_W-1:0] resp_id;
  logic                  mem_we;
  logic [MEM_AW-1:0]     mem_addr;
  logic [WORD_W-1:0]     mem_wdata;
  logic [SW_W-1:0]       switches;
  logic [HALF_W-1:0]     leds;

  logic [31:0]           lfsr_state = 32'h2e461289;
  logic [WORD_W-1:0]     mem_model [MEM_WORDS];
  logic [HALF_W-1:0]     led_model;
  logic [SW_W-1:0]       sw_val;
  logic [`DESC_ID_W-1:0] next_id;
  int                    sent;

  always #5 aclk = ~aclk;

  dma_apb_top i_dut (
    .aclk             (aclk),
    .i_rst            (rst),
    .i_desc_valid     (desc_valid),
    .o_desc_ready     (desc_ready),
    .i_desc_to_periph (desc_to_periph),
    .i_desc_sel       (desc_sel),
    .i_desc_addr      (desc_addr),
    .i_desc_len       (desc_len),
    .i_desc_id        (desc_id),
    .o_resp_valid     (resp_valid),
    .i_resp_ready     (resp_ready),
    .o_resp_id        (resp_id),
    .i_mem_we         (mem_we),
    .i_mem_addr       (mem_addr),
    .i_mem_wdata      (mem_wdata),
    .i_switch         (switches),
    .o_leds           (leds)
  );

  dma_checker mon (
    .aclk         (aclk),
    .i_rst        (rst),
    .i_desc_ready (desc_ready),
    .i_resp_valid (resp_valid),
    .i_resp_ready (resp_ready),
    .i_resp_id    (resp_id),
    .i_leds       (leds)
  );

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // LED values shown by one descriptor, collapsed, and its effect on memory.
  function automatic int ref_desc(
    input logic              to_periph,
    input logic              sel,
    input logic [MEM_AW-1:0] addr,
    input logic [LEN_W-1:0]  len,
    input logic [SW_W-1:0]   sw,
    ref   logic [WORD_W-1:0] mem [MEM_WORDS],
    ref   logic [HALF_W-1:0] last_led,
    ref   logic [HALF_W-1:0] seq [32]
  );
    int                n_words;
    int                n_seq;
    logic [MEM_AW-1:0] a;
    logic [HALF_W-1:0] half;
    n_words = (len == '0) ? 16 : int'(len);
    n_seq = 0;
    a = addr;
    for (int w = 0; w < n_words; w++) begin
      for (int h = 0; h < 2; h++) begin
        if (to_periph) begin
          half = mem[a][h*HALF_W +: HALF_W];
          if (!sel && half != last_led) begin
            last_led = half;
            seq[n_seq] = half;
            n_seq++;
          end
        end else begin
          half = sel ? {{(HALF_W - SW_W){1'b0}}, sw} : last_led;
          mem[a][h*HALF_W +: HALF_W] = half;
        end
      end
      a = a + 1'b1;
    end
    return n_seq;
  endfunction

  task automatic load_all();
    for (int i = 0; i < MEM_WORDS; i++) begin
      @(posedge aclk);
      mem_model[i] = take_bits(WORD_W);
      mem_we    <= 1'b1;
      mem_addr  <= MEM_AW'(i);
      mem_wdata <= mem_model[i];
    end
    @(posedge aclk);
    mem_we <= 1'b0;
  endtask

  task automatic send_desc(input logic to_periph, input logic sel,
                           input logic [MEM_AW-1:0] addr, input logic [LEN_W-1:0] len);
    logic [HALF_W-1:0] seq [32];
    int                n;
    n = ref_desc(to_periph, sel, addr, len, sw_val, mem_model, led_model, seq);
    for (int i = 0; i < n; i++) mon.expect_led(seq[i]);
    mon.expect_resp(next_id);
    @(posedge aclk);
    desc_valid     <= 1'b1;
    desc_to_periph <= to_periph;
    desc_sel       <= sel;
    desc_addr      <= addr;
    desc_len       <= len;
    desc_id        <= next_id;
    @(posedge aclk);
    while (!desc_ready) @(posedge aclk);
    desc_valid <= 1'b0;
    next_id = next_id + 1'b1;
    sent++;
  endtask

  task automatic wait_done();
    while (mon.resp_count < sent) @(posedge aclk);
  endtask

  initial begin
    logic [MEM_AW-1:0] addr;
    logic [LEN_W-1:0]  len;
    rst            = 1'b1;
    desc_valid     = 1'b0;
    desc_to_periph = 1'b0;
    desc_sel       = 1'b0;
    desc_addr      = '0;
    desc_len       = '0;
    desc_id        = '0;
    resp_ready     = 1'b1;
    mem_we         = 1'b0;
    mem_addr       = '0;
    mem_wdata      = '0;
    switches       = '0;
    sw_val         = '0;
    led_model      = '0;
    next_id        = '0;
    sent           = 0;
    repeat (RST_CYC) @(posedge aclk);
    rst <= 1'b0;

    load_all();
    send_desc(1'b1, 1'b0, MEM_AW'(take_bits(MEM_AW)), LEN_W'(take_bits(LEN_W)));
    wait_done();

    // Switch samples go to memory and come back out on the LEDs.
    sw_val = SW_W'(take_bits(SW_W));
    @(posedge aclk);
    switches <= sw_val;
    addr = MEM_AW'(take_bits(MEM_AW));
    len  = LEN_W'(take_bits(LEN_W));
    send_desc(1'b0, 1'b1, addr, len);
    send_desc(1'b1, 1'b0, addr, len);
    wait_done();

    @(posedge aclk);
    resp_ready <= 1'b0;
    fork
      repeat (6) send_desc(1'b1, 1'b0, MEM_AW'(take_bits(MEM_AW)), LEN_W'(1));
      begin
        repeat (STALL_CYC) @(posedge aclk);
        resp_ready <= 1'b1;  // Queue is full by now.
      end
    join
    wait_done();

    send_desc(1'b1, 1'b0, MEM_AW'(take_bits(MEM_AW)), '0);  // Sixteen words.
    wait_done();

    repeat (4) @(posedge aclk);
    mon.report();
    if (mon.error_total() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge aclk);
    $display("Timeout after %0d cycles, not all descriptors were completed", TIMEOUT_CYC);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/dma_pkg.sv
verilog/dma_if.sv
verilog/desc_queue.sv
verilog/dma_engine.sv
verilog/apb_periph.sv
verilog/dma_apb_top.sv
verification/dma_chk.sv
verification/dma_checker.sv
verification/dma_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
  --top-module dma_tb -o dma_sim \
  && ./obj_dir/dma_sim > sim.log 2>&1 \
  || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
